// File: source/cache_glue_pkg.sv
package cache_glue_pkg;

	// ----------------------------------------
	// Bus widths
	// ----------------------------------------
	localparam int WORD_W = 32;
	localparam int ADDR_W = 32;
	localparam int STRB_W = WORD_W / 8;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [STRB_W-1:0] strobe_t;	// One bit per byte lane

	// ----------------------------------------
	// Statistics
	// ----------------------------------------

	// Miss events seen in one cycle
	typedef struct packed {
		logic l1i;
		logic l1d;
		logic l2;
	} miss_ev_t;

	// Bytes per dump in the order L1I, L1D, L2
	localparam int STAT_BYTES = 3;

endpackage

// File: source/l1_req_if.sv
`timescale 1ns/1ps

// Registered core request passed from decoder to store merger
interface l1_req_if;

	cache_glue_pkg::addr_t   addr_q;
	logic                    wr;
	cache_glue_pkg::word_t   wdata;	// Raw store data from the core
	cache_glue_pkg::strobe_t strobe;

	modport drv (
		output addr_q,
		output wr,
		output wdata,
		output strobe
	);

	modport mrg (
		input addr_q,
		input wr,
		input wdata,
		input strobe
	);

endinterface

// File: source/req_decode.sv
`timescale 1ns/1ps

module req_decode #(
	parameter cache_glue_pkg::addr_t END_INST = 32'h0000_0FFC
) (
	input  logic                    clk_cpu,
	input  logic                    rst,
	input  cache_glue_pkg::addr_t   addr_i,
	input  logic                    rd_req_i,
	input  logic                    wr_req_i,
	input  cache_glue_pkg::word_t   wdata_i,
	input  cache_glue_pkg::strobe_t strobe_i,
	input  logic                    l1i_ready_i,
	input  cache_glue_pkg::word_t   l1i_rdata_i,
	input  logic                    l1d_ready_i,
	input  cache_glue_pkg::word_t   l1d_rdata_i,
	output logic                    l1i_rd_o,
	output logic                    l1d_rd_o,
	output cache_glue_pkg::addr_t   cache_addr_o,
	output logic                    rd_resp_o,
	output cache_glue_pkg::word_t   rdata_o,
	l1_req_if.drv                   req
);

	logic is_inst;	// Address falls in the instruction region
	logic inst_q;

	assign is_inst = (addr_i <= END_INST);

	// Control state
	always_ff @(posedge clk_cpu) begin
		if (rst) begin
			l1i_rd_o <= 1'b0;
			l1d_rd_o <= 1'b0;
			req.wr   <= 1'b0;
			inst_q   <= 1'b0;
		end else begin
			l1i_rd_o <= rd_req_i & is_inst;
			l1d_rd_o <= rd_req_i & ~is_inst;
			req.wr   <= wr_req_i;
			inst_q   <= is_inst;
		end
	end

	// Payload
	always_ff @(posedge clk_cpu) begin
		req.addr_q <= addr_i;
		req.wdata  <= wdata_i;
		req.strobe <= strobe_i;
	end

	assign cache_addr_o = req.addr_q;

	// Response follows the ready level of the routed cache
	assign rd_resp_o = (l1i_rd_o & l1i_ready_i) | (l1d_rd_o & l1d_ready_i);
	assign rdata_o   = inst_q ? l1i_rdata_i : l1d_rdata_i;

endmodule

// File: source/store_merge.sv
`timescale 1ns/1ps

module store_merge (
	l1_req_if.mrg                 req,
	input  cache_glue_pkg::word_t l1d_rdata_i,
	output logic                  l1d_wr_o,
	output cache_glue_pkg::word_t l1d_wdata_o
);

	cache_glue_pkg::word_t lane_mask;

	// Widen each strobe bit to its byte lane
	always_comb begin
		for (int i = 0; i < cache_glue_pkg::STRB_W; i++) begin
			lane_mask[i*8 +: 8] = {8{req.strobe[i]}};
		end
	end

	always_comb begin
		unique case (req.strobe)
			4'b0001,
			4'b0010,
			4'b0100,
			4'b1000,	// Byte
			4'b0011,
			4'b1100,	// Half word
			4'b1111: begin
				l1d_wdata_o = (req.wdata & lane_mask) | (l1d_rdata_i & ~lane_mask);
			end
			default: begin
				l1d_wdata_o = '0;	// Misaligned or empty strobe
			end
		endcase
	end

	assign l1d_wr_o = req.wr;

endmodule

// File: source/miss_counter.sv
`timescale 1ns/1ps

module miss_counter (
	input  logic                     clk_cpu,
	input  logic                     rst,
	input  cache_glue_pkg::miss_ev_t miss_i,
	input  logic                     dump_i,
	output logic                     push_o,
	output logic [7:0]               byte_o
);

	localparam int NB = cache_glue_pkg::STAT_BYTES;
	localparam int SW = $clog2(NB + 1);

	logic [NB-1:0]   hit;
	logic [7:0]      cnt     [NB];
	logic [7:0]      cnt_nxt [NB];
	logic [NB*8-1:0] snap;	// L1I in the low byte
	logic [SW-1:0]   step;	// Zero when idle

	function automatic logic [7:0] sat_inc(input logic [7:0] c, input logic h);
		return (h && c != 8'hFF) ? c + 8'd1 : c;
	endfunction

	assign hit = {miss_i.l2, miss_i.l1d, miss_i.l1i};

	always_comb begin
		for (int i = 0; i < NB; i++) begin
			cnt_nxt[i] = sat_inc(cnt[i], hit[i]);
		end
	end

	always_ff @(posedge clk_cpu) begin
		if (rst) begin
			step <= '0;
			for (int i = 0; i < NB; i++) cnt[i] <= 8'd0;
		end else if (step == '0 && dump_i) begin
			step <= SW'(1);
			for (int i = 0; i < NB; i++) cnt[i] <= 8'd0;	// Restart for the next dump
		end else begin
			for (int i = 0; i < NB; i++) cnt[i] <= cnt_nxt[i];
			if (step != '0) step <= (step == SW'(NB)) ? '0 : step + SW'(1);
		end
	end

	// Snapshot taken with the misses of the dump cycle included
	always_ff @(posedge clk_cpu) begin
		if (step == '0 && dump_i) begin
			for (int i = 0; i < NB; i++) snap[i*8 +: 8] <= cnt_nxt[i];
		end else if (step != '0) begin
			snap <= snap >> 8;
		end
	end

	assign push_o = (step != '0);
	assign byte_o = snap[7:0];

endmodule

// File: source/byte_fifo.sv
`timescale 1ns/1ps

module byte_fifo #(
	parameter int FIFO_DEPTH = 8
) (
	input  logic       clk_cpu,
	input  logic       rst,
	input  logic       push_i,
	input  logic [7:0] din_i,
	input  logic       pop_i,
	output logic [7:0] dout_o,
	output logic       empty_o
);

	localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CW = $clog2(FIFO_DEPTH + 1);

	logic [7:0]    mem [FIFO_DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic          do_push;
	logic          do_pop;

	function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
		return (p == AW'(FIFO_DEPTH - 1)) ? '0 : p + AW'(1);
	endfunction

	assign empty_o = (count == '0);
	assign do_push = push_i && (count != CW'(FIFO_DEPTH));	// Dropped when full
	assign do_pop  = pop_i && !empty_o;

	always_ff @(posedge clk_cpu) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) wr_ptr <= ptr_inc(wr_ptr);
			if (do_pop) rd_ptr <= ptr_inc(rd_ptr);
			if (do_push && !do_pop) count <= count + CW'(1);
			else if (do_pop && !do_push) count <= count - CW'(1);
		end
	end

	always_ff @(posedge clk_cpu) begin
		if (do_push) mem[wr_ptr] <= din_i;
	end

	assign dout_o = mem[rd_ptr];	// Head byte

endmodule

// File: source/uart_tx.sv
`timescale 1ns/1ps

module uart_tx #(
	parameter int CLKS_PER_BIT = 8
) (
	input  logic       clk_cpu,
	input  logic       rst,
	input  logic       empty_i,
	input  logic [7:0] din_i,
	output logic       pop_o,
	output logic       tx_o
);

	localparam int CW = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

	typedef enum logic [1:0] {ST_IDLE, ST_START, ST_DATA, ST_STOP} state_t;

	state_t        state;
	logic [CW-1:0] tick;	// Bit period counter
	logic [2:0]    bit_idx;
	logic [7:0]    sh;
	logic          bit_done;

	assign bit_done = (tick == CW'(CLKS_PER_BIT - 1));

	// Next byte is taken at the end of the stop bit, so bytes go back to back
	assign pop_o = !empty_i && (state == ST_IDLE || (state == ST_STOP && bit_done));

	always_ff @(posedge clk_cpu) begin
		if (rst) begin
			state   <= ST_IDLE;
			tick    <= '0;
			bit_idx <= 3'd0;
		end else begin
			tick <= (state == ST_IDLE || bit_done) ? '0 : tick + CW'(1);
			case (state)
				ST_IDLE:  if (pop_o) state <= ST_START;
				ST_START: if (bit_done) state <= ST_DATA;
				ST_DATA: begin
					if (bit_done) begin
						bit_idx <= bit_idx + 3'd1;
						if (bit_idx == 3'd7) state <= ST_STOP;
					end
				end
				ST_STOP:  if (bit_done) state <= pop_o ? ST_START : ST_IDLE;
				default:  state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_cpu) begin
		if (pop_o) sh <= din_i;
		else if (state == ST_DATA && bit_done) sh <= sh >> 1;	// LSB first
	end

	always_comb begin
		case (state)
			ST_START: tx_o = 1'b0;
			ST_DATA:  tx_o = sh[0];
			default:  tx_o = 1'b1;	// Idle and stop
		endcase
	end

endmodule

// File: source/cache_glue_top.sv
`timescale 1ns/1ps

module cache_glue_top #(
	parameter cache_glue_pkg::addr_t END_INST     = 32'h0000_0FFC,
	parameter int                    FIFO_DEPTH   = 8,
	parameter int                    CLKS_PER_BIT = 8
) (
	input  logic                    clk_cpu,
	input  logic                    rst,
	// Core side
	input  cache_glue_pkg::addr_t   addr_i,
	input  logic                    rd_req_i,
	input  logic                    wr_req_i,
	input  cache_glue_pkg::word_t   wdata_i,
	input  cache_glue_pkg::strobe_t strobe_i,
	output logic                    rd_resp_o,
	output cache_glue_pkg::word_t   rdata_o,
	// Cache side
	output logic                    l1i_rd_o,
	output logic                    l1d_rd_o,
	output logic                    l1d_wr_o,
	output cache_glue_pkg::word_t   l1d_wdata_o,
	output cache_glue_pkg::addr_t   cache_addr_o,
	input  logic                    l1i_ready_i,
	input  cache_glue_pkg::word_t   l1i_rdata_i,
	input  logic                    l1d_ready_i,
	input  cache_glue_pkg::word_t   l1d_rdata_i,
	// Statistics
	input  logic                    miss_l1i_i,
	input  logic                    miss_l1d_i,
	input  logic                    miss_l2_i,
	input  logic                    dump_i,
	output logic                    tx_o
);

	cache_glue_pkg::miss_ev_t miss_ev;
	logic                     push;
	logic [7:0]               push_byte;
	logic                     pop;
	logic [7:0]               head_byte;
	logic                     fifo_empty;

	assign miss_ev.l1i = miss_l1i_i;
	assign miss_ev.l1d = miss_l1d_i;
	assign miss_ev.l2  = miss_l2_i;

	l1_req_if u_req_if ();

	// ----------------------------------------
	// Request path
	// ----------------------------------------
	req_decode #(
		.END_INST     (END_INST)
	) u_req_decode (
		.clk_cpu      (clk_cpu),
		.rst          (rst),
		.addr_i       (addr_i),
		.rd_req_i     (rd_req_i),
		.wr_req_i     (wr_req_i),
		.wdata_i      (wdata_i),
		.strobe_i     (strobe_i),
		.l1i_ready_i  (l1i_ready_i),
		.l1i_rdata_i  (l1i_rdata_i),
		.l1d_ready_i  (l1d_ready_i),
		.l1d_rdata_i  (l1d_rdata_i),
		.l1i_rd_o     (l1i_rd_o),
		.l1d_rd_o     (l1d_rd_o),
		.cache_addr_o (cache_addr_o),
		.rd_resp_o    (rd_resp_o),
		.rdata_o      (rdata_o),
		.req          (u_req_if.drv)
	);

	store_merge u_store_merge (
		.req          (u_req_if.mrg),
		.l1d_rdata_i  (l1d_rdata_i),
		.l1d_wr_o     (l1d_wr_o),
		.l1d_wdata_o  (l1d_wdata_o)
	);

	// ----------------------------------------
	// Statistics path
	// ----------------------------------------
	miss_counter u_miss_counter (
		.clk_cpu      (clk_cpu),
		.rst          (rst),
		.miss_i       (miss_ev),
		.dump_i       (dump_i),
		.push_o       (push),
		.byte_o       (push_byte)
	);

	byte_fifo #(
		.FIFO_DEPTH   (FIFO_DEPTH)
	) u_byte_fifo (
		.clk_cpu      (clk_cpu),
		.rst          (rst),
		.push_i       (push),
		.din_i        (push_byte),
		.pop_i        (pop),
		.dout_o       (head_byte),
		.empty_o      (fifo_empty)
	);

	uart_tx #(
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) u_uart_tx (
		.clk_cpu      (clk_cpu),
		.rst          (rst),
		.empty_i      (fifo_empty),
		.din_i        (head_byte),
		.pop_o        (pop),
		.tx_o         (tx_o)
	);

endmodule

// File: tests/tb_cache_glue.sv
`timescale 1ns/1ps

module tb_cache_glue;

	localparam cache_glue_pkg::addr_t END_INST = 32'h0000_0FFC;
	localparam int FIFO_DEPTH    = 8;
	localparam int CLKS_PER_BIT  = 8;
	localparam int NB            = cache_glue_pkg::STAT_BYTES;
	localparam int N_READS       = 24;
	localparam int N_STORES      = 32;
	localparam int N_MISS_CYCLES = 380;
	localparam int N_DUMPS       = 7;
	localparam int WD_CYCLES     = ((N_READS + N_STORES + N_MISS_CYCLES) * 10
		+ N_DUMPS * NB * 10 * CLKS_PER_BIT) * 2;

	logic                    clk_cpu;
	logic                    rst;
	cache_glue_pkg::addr_t   addr_i;
	logic                    rd_req_i;
	logic                    wr_req_i;
	cache_glue_pkg::word_t   wdata_i;
	cache_glue_pkg::strobe_t strobe_i;
	logic                    rd_resp_o;
	cache_glue_pkg::word_t   rdata_o;
	logic                    l1i_rd_o;
	logic                    l1d_rd_o;
	logic                    l1d_wr_o;
	cache_glue_pkg::word_t   l1d_wdata_o;
	cache_glue_pkg::addr_t   cache_addr_o;
	logic                    l1i_ready_i;
	cache_glue_pkg::word_t   l1i_rdata_i;
	logic                    l1d_ready_i;
	wire cache_glue_pkg::word_t l1d_rdata_i;
	logic                    miss_l1i_i;
	logic                    miss_l1d_i;
	logic                    miss_l2_i;
	logic                    dump_i;
	logic                    tx_o;

	cache_glue_pkg::word_t dread_word;	// Data cache read return
	cache_glue_pkg::word_t dstore_word;	// Data cache word under a store
	logic                  wr_req_d;
	int                    i_wait;
	int                    d_wait;
	int                    miss_cnt [NB];
	logic [7:0]            pend_q[$];
	logic [7:0]            exp_q[$];
	int errors  = 0;
	int n_reads = 0;
	int n_store = 0;
	int n_dumps = 0;
	int n_bytes = 0;

	assign l1d_rdata_i = l1d_ready_i ? dread_word : dstore_word;

	cache_glue_top #(
		.END_INST     (END_INST),
		.FIFO_DEPTH   (FIFO_DEPTH),
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) u_cache_glue_top (
		.clk_cpu      (clk_cpu),
		.rst          (rst),
		.addr_i       (addr_i),
		.rd_req_i     (rd_req_i),
		.wr_req_i     (wr_req_i),
		.wdata_i      (wdata_i),
		.strobe_i     (strobe_i),
		.rd_resp_o    (rd_resp_o),
		.rdata_o      (rdata_o),
		.l1i_rd_o     (l1i_rd_o),
		.l1d_rd_o     (l1d_rd_o),
		.l1d_wr_o     (l1d_wr_o),
		.l1d_wdata_o  (l1d_wdata_o),
		.cache_addr_o (cache_addr_o),
		.l1i_ready_i  (l1i_ready_i),
		.l1i_rdata_i  (l1i_rdata_i),
		.l1d_ready_i  (l1d_ready_i),
		.l1d_rdata_i  (l1d_rdata_i),
		.miss_l1i_i   (miss_l1i_i),
		.miss_l1d_i   (miss_l1d_i),
		.miss_l2_i    (miss_l2_i),
		.dump_i       (dump_i),
		.tx_o         (tx_o)
	);

	initial begin
		clk_cpu = 1'b0;
		forever #10 clk_cpu = ~clk_cpu;
	end

	// ----------------------------------------
	// Reporting
	// ----------------------------------------
	task automatic report_mismatch(input string sig, input logic [31:0] exp, input logic [31:0] act);
		errors++;
		$display("Fail at %0d ns: %s expected %h, got %h", $time, sig, exp, act);
	endtask

	task automatic report_error(input string what);
		errors++;
		$display("Error at %0d ns: %s", $time, what);
	endtask

	task automatic finish_run();
		$display("reads %0d, stores %0d, dumps %0d, serial bytes %0d, errors %0d",
			n_reads, n_store, n_dumps, n_bytes, errors);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	endtask

	// ----------------------------------------
	// Expected values
	// ----------------------------------------
	function automatic cache_glue_pkg::word_t icache_word(input cache_glue_pkg::addr_t a);
		return {a[15:0] ^ a[31:16], ~a[15:0]};
	endfunction

	function automatic cache_glue_pkg::word_t dcache_word(input cache_glue_pkg::addr_t a);
		return ~a ^ 32'h5A3C_0F96;
	endfunction

	function automatic cache_glue_pkg::word_t merged_word(input cache_glue_pkg::word_t d,
		input cache_glue_pkg::strobe_t s, input cache_glue_pkg::word_t old);
		cache_glue_pkg::word_t res;
		if (!(s inside {4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100, 4'b1111}))
			return '0;
		for (int b = 0; b < 4; b++) res[b*8 +: 8] = s[b] ? d[b*8 +: 8] : old[b*8 +: 8];
		return res;
	endfunction

	// ----------------------------------------
	// Cache models
	// ----------------------------------------
	initial begin
		l1i_ready_i = 1'b0;
		l1d_ready_i = 1'b0;
		l1i_rdata_i = '0;
		dread_word  = '0;
		i_wait      = -1;
		d_wait      = -1;
		forever begin
			@(posedge clk_cpu);
			#2;
			if (!l1i_rd_o) begin
				i_wait      = -1;
				l1i_ready_i = 1'b0;
			end else if (i_wait < 0) i_wait = $urandom_range(4, 1);	// New request
			else if (i_wait > 0) i_wait--;
			if (l1i_rd_o && i_wait == 0) begin
				l1i_ready_i = 1'b1;
				l1i_rdata_i = icache_word(cache_addr_o);
			end
			if (!l1d_rd_o) begin
				d_wait      = -1;
				l1d_ready_i = 1'b0;
			end else if (d_wait < 0) d_wait = $urandom_range(4, 1);
			else if (d_wait > 0) d_wait--;
			if (l1d_rd_o && d_wait == 0) begin
				l1d_ready_i = 1'b1;
				dread_word  = dcache_word(cache_addr_o);
			end
		end
	end

	// ----------------------------------------
	// Checkers
	// ----------------------------------------
	routed_once: assert property (@(posedge clk_cpu) disable iff (rst) !(l1i_rd_o && l1d_rd_o))
		else report_error("both caches got a read request in the same cycle");

	always @(posedge clk_cpu) wr_req_d <= wr_req_i;

	initial forever begin
		@(negedge clk_cpu);
		if (!rst) begin
			assert (l1d_wr_o == wr_req_d)
				else report_mismatch("l1d_wr_o", 32'(wr_req_d), 32'(l1d_wr_o));
		end
	end

	// Serial decoder sampling tx_o at mid-bit
	initial begin
		logic [7:0] rx;
		@(negedge rst);
		forever begin
			@(negedge tx_o);
			repeat (CLKS_PER_BIT / 2) @(negedge clk_cpu);
			assert (tx_o == 1'b0) else report_error("start bit ended early on tx_o");
			for (int b = 0; b < 8; b++) begin
				repeat (CLKS_PER_BIT) @(negedge clk_cpu);
				rx[b] = tx_o;
			end
			repeat (CLKS_PER_BIT) @(negedge clk_cpu);
			assert (tx_o == 1'b1) else report_error("stop bit missing on tx_o");
			if (exp_q.size() == 0) begin
				report_error("serial byte arrived that was never expected");
			end else begin
				assert (rx == exp_q[0]) else report_mismatch("tx_o byte", 32'(exp_q[0]), 32'(rx));
				void'(exp_q.pop_front());
			end
			n_bytes++;
		end
	end

	initial begin
		repeat (WD_CYCLES) @(posedge clk_cpu);
		report_error("watchdog expired before the tests finished");
		finish_run();
	end

	// ----------------------------------------
	// Stimulus tasks
	// ----------------------------------------
	task automatic do_read(input cache_glue_pkg::addr_t a);
		logic                  inst;
		logic                  sel_rdy;
		cache_glue_pkg::word_t exp_data;
		int                    wait_cyc;
		bit                    done;
		inst     = (a <= END_INST);
		exp_data = inst ? icache_word(a) : dcache_word(a);
		wait_cyc = 0;
		done     = 1'b0;
		@(posedge clk_cpu);
		#2;
		addr_i   = a;
		rd_req_i = 1'b1;
		@(posedge clk_cpu);
		@(negedge clk_cpu);
		assert (l1i_rd_o == inst) else report_mismatch("l1i_rd_o", 32'(inst), 32'(l1i_rd_o));
		assert (l1d_rd_o == !inst) else report_mismatch("l1d_rd_o", 32'(!inst), 32'(l1d_rd_o));
		assert (cache_addr_o == a) else report_mismatch("cache_addr_o", a, cache_addr_o);
		while (!done && wait_cyc < 8) begin
			sel_rdy = inst ? l1i_ready_i : l1d_ready_i;
			assert (rd_resp_o == sel_rdy)
				else report_mismatch("rd_resp_o", 32'(sel_rdy), 32'(rd_resp_o));
			if (rd_resp_o) begin
				assert (rdata_o == exp_data) else report_mismatch("rdata_o", exp_data, rdata_o);
				done = 1'b1;
			end else begin
				wait_cyc++;
				@(negedge clk_cpu);
			end
		end
		if (!done) report_error("read response never came back");
		@(posedge clk_cpu);
		#2;
		rd_req_i = 1'b0;
		n_reads++;
	endtask

	task automatic do_store(input cache_glue_pkg::word_t d, input cache_glue_pkg::strobe_t s,
		input cache_glue_pkg::word_t old);
		cache_glue_pkg::word_t exp;
		exp = merged_word(d, s, old);
		@(posedge clk_cpu);
		#2;
		wr_req_i    = 1'b1;
		wdata_i     = d;
		strobe_i    = s;
		dstore_word = old;
		@(posedge clk_cpu);
		#2;
		wr_req_i = 1'b0;
		@(negedge clk_cpu);
		assert (l1d_wdata_o == exp) else report_mismatch("l1d_wdata_o", exp, l1d_wdata_o);
		n_store++;
	endtask

	task automatic miss_burst(input int cycles, input bit l1i_on);
		logic [2:0] m;
		repeat (cycles) begin
			@(posedge clk_cpu);
			#2;
			m = 3'($urandom);
			if (l1i_on) m[0] = 1'b1;
			miss_l1i_i = m[0];
			miss_l1d_i = m[1];
			miss_l2_i  = m[2];
			for (int i = 0; i < NB; i++) if (m[i] && miss_cnt[i] < 255) miss_cnt[i]++;
		end
	endtask

	task automatic issue_dump();
		@(posedge clk_cpu);
		#2;
		miss_l1i_i = 1'b0;
		miss_l1d_i = 1'b0;
		miss_l2_i  = 1'b0;
		dump_i     = 1'b1;
		for (int i = 0; i < NB; i++) begin
			pend_q.push_back(8'(miss_cnt[i]));
			miss_cnt[i] = 0;	// Counting restarts
		end
		@(posedge clk_cpu);
		#2;
		dump_i = 1'b0;
		n_dumps++;
	endtask

	task automatic expect_bytes(input int n);
		for (int i = 0; i < n; i++) exp_q.push_back(pend_q[i]);
		pend_q.delete();
	endtask

	task automatic wait_serial(input int limit);
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < limit) begin
			@(posedge clk_cpu);
			n++;
		end
		if (exp_q.size() != 0) report_error("expected serial bytes did not arrive");
		repeat (CLKS_PER_BIT) @(posedge clk_cpu);	// Rest of the stop bit
	endtask

	// ----------------------------------------
	// Main sequence
	// ----------------------------------------
	initial begin
		cache_glue_pkg::addr_t a;
		void'($urandom(32'hd797a1b8));
		rst         = 1'b1;
		addr_i      = '0;
		rd_req_i    = 1'b0;
		wr_req_i    = 1'b0;
		wdata_i     = '0;
		strobe_i    = '0;
		dstore_word = '0;
		miss_l1i_i  = 1'b0;
		miss_l1d_i  = 1'b0;
		miss_l2_i   = 1'b0;
		dump_i      = 1'b0;
		for (int i = 0; i < NB; i++) miss_cnt[i] = 0;
		repeat (10) @(posedge clk_cpu);
		#2;
		rst = 1'b0;
		repeat (3) begin
			@(negedge clk_cpu);
			assert (tx_o == 1'b1) else report_mismatch("tx_o", 32'd1, 32'(tx_o));
			assert (!l1i_rd_o) else report_mismatch("l1i_rd_o", 32'd0, 32'(l1i_rd_o));
			assert (!l1d_rd_o) else report_mismatch("l1d_rd_o", 32'd0, 32'(l1d_rd_o));
			assert (!l1d_wr_o) else report_mismatch("l1d_wr_o", 32'd0, 32'(l1d_wr_o));
			assert (!rd_resp_o) else report_mismatch("rd_resp_o", 32'd0, 32'(rd_resp_o));
		end

		do_read(32'h0000_0000);
		do_read(END_INST);
		do_read(END_INST + 32'd4);
		do_read(32'hFFFF_FFFC);
		for (int i = 0; i < N_READS - 4; i++) begin
			a = $urandom;
			if (i % 2 == 0) a = a & 32'h0000_1FFF;	// Near the region boundary
			do_read(a);
		end

		for (int r = 0; r < N_STORES / 16; r++) begin
			for (int s = 0; s < 16; s++) do_store($urandom, 4'(s), $urandom);
		end

		// Three plain dumps with one saturating count
		miss_burst(40, 1'b0);
		issue_dump();
		expect_bytes(NB);
		miss_burst(300, 1'b1);
		issue_dump();
		expect_bytes(NB);
		miss_burst(5, 1'b0);
		issue_dump();
		expect_bytes(NB);
		wait_serial(4 * NB * 10 * CLKS_PER_BIT);

		// Four dumps into an idle UART overrun the FIFO
		miss_burst(20, 1'b0);
		issue_dump();
		for (int k = 0; k < 3; k++) begin
			miss_burst(2, 1'b0);
			issue_dump();
		end
		expect_bytes(FIFO_DEPTH + 1);
		wait_serial((FIFO_DEPTH + 2) * 10 * CLKS_PER_BIT);
		repeat (NB * 10 * CLKS_PER_BIT) @(posedge clk_cpu);	// No stray bytes
		finish_run();
	end

endmodule

// File: src.f
source/cache_glue_pkg.sv
source/l1_req_if.sv
source/req_decode.sv
source/store_merge.sv
source/miss_counter.sv
source/byte_fifo.sv
source/uart_tx.sv
source/cache_glue_top.sv
tests/tb_cache_glue.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       ?= tb_cache_glue
FILELIST  ?= src.f

OBJ_DIR := obj_dir
SIM     := $(OBJ_DIR)/V$(TOP)
LOG     := sim.log
SRCS    := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@! grep -q "test failed" $(LOG)
	@grep -q "test passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
